// ==== files.f ====
+incdir+source
source/issue_pkg.sv
source/issue_interfaces.sv
source/dispatch_decode.sv
source/reservation_station.sv
source/alu_unit.sv
source/memory_unit.sv
source/result_bus.sv
source/issue_core.sv
verif/clock_gen.sv
verif/issue_core_tb.sv

// ==== source/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input  logic             clock,
    input  logic             reset,
    issue_if.unit            issue,
    output logic             result_valid,
    output issue_pkg::tag_t  result_tag,
    output issue_pkg::data_t result_value,
    output logic             writes_reg,
    input  logic             taken
);
    import issue_pkg::*;

    data_t alu_out;

    always_comb begin
        case (issue.func)
            ADD: alu_out = issue.a + issue.b;
            SUB: alu_out = issue.a - issue.b;
            AND: alu_out = issue.a & issue.b;
            OR:  alu_out = issue.a | issue.b;
            XOR: alu_out = issue.a ^ issue.b;
            SLL: alu_out = issue.a << issue.b[3:0];
            SRL: alu_out = issue.a >> issue.b[3:0];
            // Signed compare, result 1 or 0
            default: alu_out = data_t'($signed(issue.a) < $signed(issue.b));
        endcase
    end

    // Every ALU result goes to a register
    assign writes_reg = 1'b1;
    // Blocked until the offer is taken
    assign issue.free = !result_valid;

    always_ff @(posedge clock) begin
        if (reset) result_valid <= 1'b0;
        else if (issue.valid) result_valid <= 1'b1;
        else if (taken) result_valid <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (issue.valid) begin
            result_tag   <= issue.tag;
            result_value <= alu_out;
        end
    end

endmodule

// ==== source/dispatch_decode.sv ====
`timescale 1ns/1ps
`include "issue_settings.svh"

module dispatch_decode (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  issue_pkg::instr_u dispatch_instr,
    output logic              dispatch_ready,
    input  logic [2:0]        station_busy,
    dispatch_if.decode        dp,
    cdb_if.listen             cdb
);
    import issue_pkg::*;

    // Register file and rename map
    data_t                 regs [`REG_COUNT];
    logic [`REG_COUNT-1:0] pending;
    tag_t                  map_tag [`REG_COUNT];
    tag_t                  next_tag;

    // Decoded fields
    opcode_e    opcode;
    reg_idx_t   dest;
    logic       writes_dest;
    logic [1:0] use_reg;
    reg_idx_t   src [2];
    data_t      offset;
    logic       accept;

    assign opcode = dispatch_instr.alu.opcode;
    assign offset = data_t'(dispatch_instr.mem.offset);

    ///////////////////////////////////////////////////////////////////////
    // Decode
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        dest        = dispatch_instr.alu.rd;
        writes_dest = 1'b1;
        use_reg     = 2'b11;
        src[0]      = dispatch_instr.alu.rs1;
        src[1]      = dispatch_instr.alu.rs2;
        dp.fu_class = FU_ALU;
        dp.func     = ADD;
        case (opcode)
            OP_ALU: dp.func = dispatch_instr.alu.func;
            // Load immediate runs as 0 + offset on the ALU
            OP_LOAD_IMM: use_reg = 2'b00;
            OP_LOAD: begin
                dp.fu_class = FU_LOAD;
                src[0]      = dispatch_instr.mem.rs1;
                use_reg     = 2'b01;
            end
            OP_STORE: begin
                dp.fu_class = FU_STORE;
                src[0]      = dispatch_instr.mem.rs1;
                src[1]      = dispatch_instr.mem.rd;
                writes_dest = 1'b0;
            end
            default: dp.func = ADD;
        endcase
    end

    // Operand source: constant, register file, CDB bypass, or wait
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            dp.op_tag[k] = map_tag[src[k]];
            if (!use_reg[k]) begin
                dp.op_ready[k] = 1'b1;
                dp.op_value[k] = (k == 1) ? offset : '0;
            end else if (!pending[src[k]]) begin
                dp.op_ready[k] = 1'b1;
                dp.op_value[k] = regs[src[k]];
            end else if (cdb.valid && cdb.tag == map_tag[src[k]]) begin
                dp.op_ready[k] = 1'b1;
                dp.op_value[k] = cdb.value;
            end else begin
                dp.op_ready[k] = 1'b0;
                dp.op_value[k] = '0;
            end
        end
    end

    // Loads and stores also wait on each other, keeps memory order
    always_comb begin
        case (dp.fu_class)
            FU_LOAD, FU_STORE:
                dispatch_ready = !station_busy[FU_LOAD] && !station_busy[FU_STORE];
            default: dispatch_ready = !station_busy[FU_ALU];
        endcase
    end

    assign accept   = dispatch_valid && dispatch_ready;
    assign dp.valid = accept;
    assign dp.tag   = next_tag;
    assign dp.imm   = offset;

    ///////////////////////////////////////////////////////////////////////
    // Register file, map and tag counter
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= '0;
            pending  <= '0;
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r]    <= '0;
                map_tag[r] <= '0;
            end
        end else begin
            // Write back only if the map still names this tag
            if (cdb.valid && cdb.writes_reg) begin
                for (int r = 0; r < `REG_COUNT; r++) begin
                    if (pending[r] && map_tag[r] == cdb.tag) begin
                        regs[r]    <= cdb.value;
                        pending[r] <= 1'b0;
                    end
                end
            end
            // Rename comes last so it beats a same-cycle write
            if (accept) begin
                next_tag <= (next_tag == tag_t'(`TAG_COUNT - 1)) ? '0 : next_tag + 1'b1;
                if (writes_dest) begin
                    pending[dest] <= 1'b1;
                    map_tag[dest] <= next_tag;
                end
            end
        end
    end

endmodule

// ==== source/issue_core.sv ====
`timescale 1ns/1ps

module issue_core (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  issue_pkg::instr_u dispatch_instr,
    output logic              dispatch_ready,
    output logic              result_valid,
    output issue_pkg::tag_t   result_tag,
    output issue_pkg::data_t  result_value,
    output logic              result_writes
);
    import issue_pkg::*;

    dispatch_if dp ();
    issue_if    alu_issue ();
    issue_if    mem_issue ();
    cdb_if      cdb ();

    logic [2:0] station_busy;

    // Unit result offers
    logic  alu_valid, alu_writes, alu_taken;
    tag_t  alu_tag;
    data_t alu_value;
    logic  mem_valid, mem_writes, mem_taken;
    tag_t  mem_tag;
    data_t mem_value;

    dispatch_decode decode_i (
        .clock, .reset, .dispatch_valid, .dispatch_instr, .dispatch_ready,
        .station_busy, .dp(dp.decode), .cdb(cdb.listen)
    );

    reservation_station station_i (
        .clock, .reset, .dp(dp.station), .cdb(cdb.listen),
        .alu_issue(alu_issue.station), .mem_issue(mem_issue.station), .station_busy
    );

    alu_unit alu_i (
        .clock, .reset, .issue(alu_issue.unit), .result_valid(alu_valid),
        .result_tag(alu_tag), .result_value(alu_value), .writes_reg(alu_writes),
        .taken(alu_taken)
    );

    memory_unit mem_i (
        .clock, .reset, .issue(mem_issue.unit), .result_valid(mem_valid),
        .result_tag(mem_tag), .result_value(mem_value), .writes_reg(mem_writes),
        .taken(mem_taken)
    );

    result_bus bus_i (
        .alu_valid, .alu_tag, .alu_value, .alu_writes, .alu_taken,
        .mem_valid, .mem_tag, .mem_value, .mem_writes, .mem_taken,
        .cdb(cdb.bus), .result_valid, .result_tag, .result_value, .result_writes
    );

endmodule

// ==== source/issue_interfaces.sv ====
`timescale 1ns/1ps

// Decode to reservation station, one strobe per accepted dispatch
interface dispatch_if;
    import issue_pkg::*;

    logic      valid;
    fu_class_e fu_class;
    tag_t      tag;
    alu_func_e func;
    data_t     imm;
    // Per operand: ready bit, captured value, tag to wait for
    logic [1:0] op_ready;
    data_t      op_value [2];
    tag_t       op_tag [2];

    modport decode (output valid, fu_class, tag, func, imm, op_ready, op_value, op_tag);
    modport station (input valid, fu_class, tag, func, imm, op_ready, op_value, op_tag);
endinterface

// Station to one execute unit
interface issue_if;
    import issue_pkg::*;

    logic      valid;
    tag_t      tag;
    alu_func_e func;
    data_t     a;
    data_t     b;
    data_t     imm;
    logic      load_not_store;
    // Unit can take a new operation
    logic      free;

    modport station (output valid, tag, func, a, b, imm, load_not_store, input free);
    modport unit (input valid, tag, func, a, b, imm, load_not_store, output free);
endinterface

// Common data bus broadcast
interface cdb_if;
    import issue_pkg::*;

    logic  valid;
    tag_t  tag;
    data_t value;
    logic  writes_reg;

    modport bus (output valid, tag, value, writes_reg);
    modport listen (input valid, tag, value, writes_reg);
endinterface

// ==== source/issue_pkg.sv ====
`include "issue_settings.svh"

package issue_pkg;

    // Scalar types
    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [2:0] reg_idx_t;
    typedef logic [2:0] tag_t;
    typedef logic [3:0] mem_addr_t;

    typedef enum logic [1:0] {
        OP_ALU      = 2'd0,
        OP_LOAD     = 2'd1,
        OP_STORE    = 2'd2,
        OP_LOAD_IMM = 2'd3
    } opcode_e;

    // SLL and SRL use b[3:0], SLT is signed
    typedef enum logic [2:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SLT
    } alu_func_e;

    // Also the station entry index
    typedef enum logic [1:0] {
        FU_ALU   = 2'd0,
        FU_LOAD  = 2'd1,
        FU_STORE = 2'd2
    } fu_class_e;

    ///////////////////////////////////////////////////////////////////////
    // Instruction word, register form and memory form
    ///////////////////////////////////////////////////////////////////////

    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        alu_func_e  func;
        logic [1:0] spare;
    } alu_view_t;

    // Store: rd is the data register, rs1 the base
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        logic [7:0] offset;
    } mem_view_t;

    typedef union packed {
        alu_view_t alu;
        mem_view_t mem;
    } instr_u;

endpackage

// ==== source/issue_settings.svh ====
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Width of every data word, register and memory word
`define DATA_WIDTH 16

// Architectural registers
`define REG_COUNT 8

// Tag space, the counter wraps here
`define TAG_COUNT 8

// Words in the data memory
`define MEM_DEPTH 16

`endif

// ==== source/memory_unit.sv ====
`timescale 1ns/1ps
`include "issue_settings.svh"

module memory_unit (
    input  logic             clock,
    input  logic             reset,
    issue_if.unit            issue,
    output logic             result_valid,
    output issue_pkg::tag_t  result_tag,
    output issue_pkg::data_t result_value,
    output logic             writes_reg,
    input  logic             taken
);
    import issue_pkg::*;

    data_t mem [`MEM_DEPTH];

    // Address stage
    logic      s1_valid;
    logic      s1_load;
    tag_t      s1_tag;
    mem_addr_t s1_addr;
    data_t     s1_data;

    // One operation at a time in the pipe
    assign issue.free = !s1_valid && !result_valid;

    ///////////////////////////////////////////////////////////////////////
    // Control and memory write
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
            for (int w = 0; w < `MEM_DEPTH; w++) begin
                mem[w] <= '0;
            end
        end else begin
            s1_valid <= issue.valid;
            if (s1_valid) begin
                result_valid <= 1'b1;
                if (!s1_load) mem[s1_addr] <= s1_data;
            end else if (taken) begin
                result_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        // Stage 1, base plus offset wraps in 16 words
        if (issue.valid) begin
            s1_load <= issue.load_not_store;
            s1_tag  <= issue.tag;
            s1_addr <= mem_addr_t'(issue.a + issue.imm);
            s1_data <= issue.b;
        end
        // Stage 2, store reports its data with writes low
        if (s1_valid) begin
            result_tag   <= s1_tag;
            result_value <= s1_load ? mem[s1_addr] : s1_data;
            writes_reg   <= s1_load;
        end
    end

endmodule

// ==== source/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station (
    input  logic        clock,
    input  logic        reset,
    dispatch_if.station dp,
    cdb_if.listen       cdb,
    issue_if.station    alu_issue,
    issue_if.station    mem_issue,
    output logic [2:0]  station_busy
);
    import issue_pkg::*;

    // One entry per class, indexed by fu_class_e
    logic [2:0] busy;
    logic [2:0] issued;
    tag_t       tag [3];
    alu_func_e  func [3];
    data_t      imm [3];
    logic [1:0] op_ready [3];
    data_t      op_value [3][2];
    tag_t       op_tag [3][2];

    logic [2:0] ready;
    logic       alu_fire;
    logic       mem_fire;
    fu_class_e  mem_sel;

    assign station_busy = busy;

    ///////////////////////////////////////////////////////////////////////
    // Issue select
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int e = 0; e < 3; e++) begin
            ready[e] = busy[e] && !issued[e] && (&op_ready[e]);
        end
    end

    // Skip the cycle of a strobe, free drops one cycle later
    assign alu_fire = ready[FU_ALU] && alu_issue.free && !alu_issue.valid;
    // Dispatch stall keeps at most one of LOAD and STORE present
    assign mem_sel  = ready[FU_STORE] ? FU_STORE : FU_LOAD;
    assign mem_fire = (ready[FU_LOAD] || ready[FU_STORE]) && mem_issue.free && !mem_issue.valid;

    assign alu_issue.load_not_store = 1'b0;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy            <= '0;
            issued          <= '0;
            alu_issue.valid <= 1'b0;
            mem_issue.valid <= 1'b0;
        end else begin
            alu_issue.valid <= alu_fire;
            mem_issue.valid <= mem_fire;
            if (alu_fire) issued[FU_ALU] <= 1'b1;
            if (mem_fire) issued[mem_sel] <= 1'b1;
            for (int e = 0; e < 3; e++) begin
                // Wakeup of waiting operands
                for (int k = 0; k < 2; k++) begin
                    if (busy[e] && !op_ready[e][k] && cdb.valid && cdb.tag == op_tag[e][k]) begin
                        op_ready[e][k] <= 1'b1;
                        op_value[e][k] <= cdb.value;
                    end
                end
                // Own broadcast frees the entry
                if (busy[e] && issued[e] && cdb.valid && cdb.tag == tag[e]) busy[e] <= 1'b0;
            end
            // Target entry is idle, no clash with the loops above
            if (dp.valid) begin
                busy[dp.fu_class]     <= 1'b1;
                issued[dp.fu_class]   <= 1'b0;
                tag[dp.fu_class]      <= dp.tag;
                func[dp.fu_class]     <= dp.func;
                imm[dp.fu_class]      <= dp.imm;
                op_ready[dp.fu_class] <= dp.op_ready;
                for (int k = 0; k < 2; k++) begin
                    op_value[dp.fu_class][k] <= dp.op_value[k];
                    op_tag[dp.fu_class][k]   <= dp.op_tag[k];
                end
            end
        end
    end

    // Issue payload registers
    always_ff @(posedge clock) begin
        if (alu_fire) begin
            alu_issue.tag  <= tag[FU_ALU];
            alu_issue.func <= func[FU_ALU];
            alu_issue.a    <= op_value[FU_ALU][0];
            alu_issue.b    <= op_value[FU_ALU][1];
            alu_issue.imm  <= imm[FU_ALU];
        end
        if (mem_fire) begin
            mem_issue.tag            <= tag[mem_sel];
            mem_issue.func           <= func[mem_sel];
            mem_issue.a              <= op_value[mem_sel][0];
            mem_issue.b              <= op_value[mem_sel][1];
            mem_issue.imm            <= imm[mem_sel];
            mem_issue.load_not_store <= (mem_sel == FU_LOAD);
        end
    end

endmodule

// ==== source/result_bus.sv ====
`timescale 1ns/1ps

module result_bus (
    input  logic             alu_valid,
    input  issue_pkg::tag_t  alu_tag,
    input  issue_pkg::data_t alu_value,
    input  logic             alu_writes,
    output logic             alu_taken,
    input  logic             mem_valid,
    input  issue_pkg::tag_t  mem_tag,
    input  issue_pkg::data_t mem_value,
    input  logic             mem_writes,
    output logic             mem_taken,
    cdb_if.bus               cdb,
    output logic             result_valid,
    output issue_pkg::tag_t  result_tag,
    output issue_pkg::data_t result_value,
    output logic             result_writes
);
    // Fixed priority, memory unit first
    always_comb begin
        result_valid = alu_valid || mem_valid;
        mem_taken    = mem_valid;
        alu_taken    = alu_valid && !mem_valid;
        if (mem_valid) begin
            result_tag    = mem_tag;
            result_value  = mem_value;
            result_writes = mem_writes;
        end else begin
            result_tag    = alu_tag;
            result_value  = alu_value;
            result_writes = alu_writes;
        end
    end

    // Broadcast is the same word
    assign cdb.valid      = result_valid;
    assign cdb.tag        = result_tag;
    assign cdb.value      = result_value;
    assign cdb.writes_reg = result_writes;

endmodule

// ==== verif/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic reset
);
    // 20 ns period, starts low
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // High through five rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

// ==== verif/issue_core_tb.sv ====
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_core_tb;
    import issue_pkg::*;

    localparam int CLOCK_PERIOD = 20;
    localparam int ALU_COUNT    = 64;
    localparam int CHAIN_COUNT  = 200;
    localparam int MEM_COUNT    = 160;
    localparam int BURST_COUNT  = 120;
    localparam int MIXED_COUNT  = 400;
    localparam int TOTAL_INSTR  = `REG_COUNT + ALU_COUNT + CHAIN_COUNT + MEM_COUNT
                                  + BURST_COUNT + MIXED_COUNT;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 40 + 200;
    localparam int STALL_LIMIT  = 100;
    localparam int DRAIN_LIMIT  = 100;

    logic   clock;
    logic   reset;
    logic   dispatch_valid;
    instr_u dispatch_instr;
    logic   dispatch_ready;
    logic   result_valid;
    tag_t   result_tag;
    data_t  result_value;
    logic   result_writes;

    // Reference model state updated in program order at acceptance
    data_t                 model_regs [`REG_COUNT];
    data_t                 model_mem [`MEM_DEPTH];
    tag_t                  model_tag;
    logic [`TAG_COUNT-1:0] outstanding;
    logic [`TAG_COUNT-1:0] ever_dispatched;
    data_t                 exp_value [`TAG_COUNT];
    logic [`TAG_COUNT-1:0] exp_writes;

    // Run bookkeeping
    int   in_flight;
    int   dispatched;
    int   results;
    int   failures;
    int   mark_dispatched;
    int   mark_results;
    int   mark_failures;
    logic stuck;

    clock_gen clock_gen_i (.clock, .reset);

    issue_core issue_core_i (
        .clock, .reset, .dispatch_valid, .dispatch_instr, .dispatch_ready,
        .result_valid, .result_tag, .result_value, .result_writes
    );

    ///////////////////////////////////////////////////////////////////////
    // Instruction encoding and the reference model
    ///////////////////////////////////////////////////////////////////////

    function automatic instr_u alu_word(alu_func_e f, reg_idx_t rd, reg_idx_t rs1,
                                        reg_idx_t rs2);
        instr_u w;
        w.alu.opcode = OP_ALU;
        w.alu.rd     = rd;
        w.alu.rs1    = rs1;
        w.alu.rs2    = rs2;
        w.alu.func   = f;
        w.alu.spare  = 2'b00;
        return w;
    endfunction

    // Store uses rd as the data register and load_imm ignores rs1
    function automatic instr_u mem_word(opcode_e op, reg_idx_t rd, reg_idx_t rs1,
                                        logic [7:0] offset);
        instr_u w;
        w.mem.opcode = op;
        w.mem.rd     = rd;
        w.mem.rs1    = rs1;
        w.mem.offset = offset;
        return w;
    endfunction

    function automatic reg_idx_t rand_reg(int span);
        return reg_idx_t'($urandom_range(span - 1, 0));
    endfunction

    // Percentages pick the opcode and ALU gets the remainder
    function automatic instr_u random_instr(int store_pct, int load_pct, int imm_pct, int span);
        int         pick;
        logic [7:0] offset;
        instr_u     w;
        pick   = $urandom_range(99, 0);
        offset = 8'($urandom_range(255, 0));
        if (pick < store_pct)
            w = mem_word(OP_STORE, rand_reg(span), rand_reg(span), offset);
        else if (pick < store_pct + load_pct)
            w = mem_word(OP_LOAD, rand_reg(span), rand_reg(span), offset);
        else if (pick < store_pct + load_pct + imm_pct)
            w = mem_word(OP_LOAD_IMM, rand_reg(span), '0, offset);
        else
            w = alu_word(alu_func_e'($urandom_range(7, 0)), rand_reg(span), rand_reg(span),
                         rand_reg(span));
        return w;
    endfunction

    function automatic data_t alu_model(alu_func_e f, data_t a, data_t b);
        data_t      result;
        logic [3:0] amount;
        amount = b[3:0];
        case (f)
            ADD: result = a + b;
            SUB: result = a + ~b + 1'b1;
            AND: result = a & b;
            OR:  result = a | b;
            XOR: result = a ^ b;
            SLL: result = a << amount;
            SRL: result = a >> amount;
            // Differing signs decide by the sign of a and equal signs by unsigned order
            default: begin
                if (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1])
                    result = data_t'(a[`DATA_WIDTH-1]);
                else
                    result = data_t'(a < b);
            end
        endcase
        return result;
    endfunction

    task automatic record_dispatch(input instr_u ins);
        data_t     value;
        data_t     sum;
        mem_addr_t addr;
        logic      writes;
        writes = 1'b1;
        sum    = model_regs[ins.mem.rs1] + data_t'(ins.mem.offset);
        addr   = sum[3:0];
        case (ins.alu.opcode)
            OP_ALU:
                value = alu_model(ins.alu.func, model_regs[ins.alu.rs1],
                                  model_regs[ins.alu.rs2]);
            OP_LOAD_IMM: value = data_t'(ins.mem.offset);
            OP_LOAD: value = model_mem[addr];
            default: begin
                // Store reports its data but writes no register
                value          = model_regs[ins.mem.rd];
                model_mem[addr] = value;
                writes         = 1'b0;
            end
        endcase
        if (writes) model_regs[ins.alu.rd] = value;
        if (outstanding[model_tag]) begin
            $display("Tag %0d handed out again while still in flight", model_tag);
            failures++;
        end
        outstanding[model_tag]     = 1'b1;
        ever_dispatched[model_tag] = 1'b1;
        exp_value[model_tag]       = value;
        exp_writes[model_tag]      = writes;
        // Three-bit tag wraps at 8
        model_tag = model_tag + 1'b1;
        in_flight++;
        dispatched++;
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Compare tasks
    ///////////////////////////////////////////////////////////////////////

    task automatic check_level(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Fail %s got %h expected %h", name, got, expected);
            failures++;
        end
    endtask

    task automatic check_tag(input tag_t got, output logic known);
        known = outstanding[got];
        if (!known) begin
            if (!ever_dispatched[got])
                $display("Result broadcast for tag %0d which was never dispatched", got);
            else
                $display("Result broadcast for tag %0d which has no outstanding dispatch", got);
            failures++;
        end
    endtask

    task automatic check_value(input tag_t tag, input data_t got, input data_t expected);
        if (got !== expected) begin
            $display("Fail result_value tag %0d got %h expected %h", tag, got, expected);
            failures++;
        end
    endtask

    task automatic check_writes(input tag_t tag, input logic got, input logic expected);
        if (got !== expected) begin
            $display("Fail result_writes tag %0d got %h expected %h", tag, got, expected);
            failures++;
        end
    endtask

    // Outputs settle after the rising edge and are sampled on the falling edge
    initial begin
        logic known;
        forever begin
            @(negedge clock);
            if (!reset && result_valid === 1'b1) begin
                results++;
                check_tag(result_tag, known);
                if (known) begin
                    check_value(result_tag, result_value, exp_value[result_tag]);
                    check_writes(result_tag, result_writes, exp_writes[result_tag]);
                    outstanding[result_tag] = 1'b0;
                    in_flight--;
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus
    ///////////////////////////////////////////////////////////////////////

    // Drive on the falling edge and hold until ready is seen before a rising edge
    task automatic dispatch_one(input instr_u ins, input int gap);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        for (int g = 0; g < gap; g++) begin
            @(negedge clock);
            dispatch_valid = 1'b0;
        end
        while (!accepted && !stuck) begin
            @(negedge clock);
            dispatch_valid = 1'b1;
            dispatch_instr = ins;
            #1;
            if (dispatch_ready) begin
                accepted = 1'b1;
                record_dispatch(ins);
            end else begin
                waited++;
                if (waited > STALL_LIMIT) begin
                    $display("Dispatch stalled for more than %0d cycles", STALL_LIMIT);
                    failures++;
                    stuck = 1'b1;
                end
            end
        end
    endtask

    task automatic run_random(input int count, input int store_pct, input int load_pct,
                              input int imm_pct, input int span, input int gap_pct);
        for (int i = 0; i < count; i++) begin
            dispatch_one(random_instr(store_pct, load_pct, imm_pct, span),
                         ($urandom_range(99, 0) < gap_pct) ? 1 : 0);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clock);
        dispatch_valid = 1'b0;
        #2;
        while (in_flight > 0 && waited < DRAIN_LIMIT && !stuck) begin
            @(negedge clock);
            #2;
            waited++;
        end
        if (in_flight > 0 && !stuck) begin
            $display("%0d results still missing after the drain", in_flight);
            failures++;
            stuck = 1'b1;
        end
    endtask

    task automatic start_test();
        mark_dispatched = dispatched;
        mark_results    = results;
        mark_failures   = failures;
    endtask

    task automatic finish_test(input int number, input string name);
        drain();
        if (results - mark_results != dispatched - mark_dispatched) begin
            $display("Test %0d saw %0d results for %0d accepted dispatches", number,
                     results - mark_results, dispatched - mark_dispatched);
            failures++;
        end
        $display("test %0d %s: %0d dispatched, %0d results, %0d failures", number, name,
                 dispatched - mark_dispatched, results - mark_results,
                 failures - mark_failures);
    endtask

    initial begin
        dispatch_valid  = 1'b0;
        dispatch_instr  = '0;
        model_tag       = '0;
        outstanding     = '0;
        ever_dispatched = '0;
        exp_writes      = '0;
        in_flight       = 0;
        dispatched      = 0;
        results         = 0;
        failures        = 0;
        stuck           = 1'b0;
        for (int r = 0; r < `REG_COUNT; r++) model_regs[r] = '0;
        for (int w = 0; w < `MEM_DEPTH; w++) model_mem[w] = '0;
        void'($urandom(32'h6e53));
        @(negedge reset);
        @(negedge clock);

        // Reset levels and then every function on registers set by load_imm
        start_test();
        check_level("result_valid", result_valid, 1'b0);
        check_level("dispatch_ready", dispatch_ready, 1'b1);
        for (int r = 0; r < `REG_COUNT; r++) begin
            dispatch_one(mem_word(OP_LOAD_IMM, reg_idx_t'(r), '0,
                                  8'($urandom_range(255, 0))), 0);
        end
        for (int i = 0; i < ALU_COUNT; i++) begin
            dispatch_one(alu_word(alu_func_e'(i % 8), rand_reg(8), rand_reg(8), rand_reg(8)), 0);
        end
        finish_test(1, "alu functions");

        // Three registers only give dense RAW and WAW hazards
        start_test();
        run_random(CHAIN_COUNT, 0, 0, 25, 3, 30);
        finish_test(2, "dependency chains");

        start_test();
        run_random(MEM_COUNT, 35, 35, 10, 8, 20);
        finish_test(3, "memory order");

        // No idle cycles so results pile up behind the bus
        start_test();
        run_random(BURST_COUNT, 15, 15, 15, 4, 0);
        finish_test(4, "back-pressure");

        start_test();
        run_random(MIXED_COUNT, 20, 20, 15, 8, 25);
        finish_test(5, "mixed random");

        $display("all tests: %0d dispatched, %0d results, %0d outstanding, %0d failures",
                 dispatched, results, in_flight, failures);
        if (failures == 0 && in_flight == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Budget of 40 cycles per instruction plus slack
    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule
